// ==== Bender.yml ====
package:
  name: jsp

sources:
  # RTL, packages first
  - files:
      - hw/jsp_jtag_pkg.sv
      - hw/jsp_buf_pkg.sv
      - hw/jsp_byte_fifo.sv
      - hw/jsp_write_ctrl.sv
      - hw/jsp_read_ctrl.sv
      - hw/jsp_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/jsp_assert.sv
      - dv/jsp_tb.sv

// ==== dv/jsp_assert.sv ====
//////////////////////////////////////////////////
// JSP core checks
// Buffer use and strobe timing, bound to jsp_top
//////////////////////////////////////////////////

module jsp_assert
  import jsp_jtag_pkg::*;
  import jsp_buf_pkg::*;
(
  input logic        tck_i,
  input logic        rst_i,
  input tap_ctrl_t   tap_i,
  input logic        rx_push_i,
  input logic        tx_pop_i,
  input fifo_level_t rx_level_i,
  input fifo_level_t tx_level_i,
  input logic        tdo_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fails = 0;  // Failed assertions so far

  // Free space snapshot keeps the receive FIFO from overrunning
  rx_no_overflow: assert property (@(posedge tck_i) disable iff (rst_i)
    rx_push_i |-> (rx_level_i.free != '0))
    else begin
      fails++;
      $error("push into a full receive FIFO");
    end

  tx_no_underflow: assert property (@(posedge tck_i) disable iff (rst_i)
    tx_pop_i |-> (tx_level_i.used != '0))  // Used count snapshot
    else begin
      fails++;
      $error("pop from an empty transmit FIFO");
    end

  // JTAG side FIFO changes only follow Shift-DR cycles
  strobe_in_shift: assert property (@(posedge tck_i) disable iff (rst_i)
    ((rx_level_i.used > $past(rx_level_i.used)) ||
     (tx_level_i.used < $past(tx_level_i.used))) |-> $past(tap_i.shift))
    else begin
      fails++;
      $error("FIFO strobe outside a shift cycle");
    end

  tdo_low_after_reset: assert property (@(posedge tck_i)
    $fell(rst_i) |-> !tdo_i)
    else begin
      fails++;
      $error("tdo_o high in the first cycle after reset");
    end

endmodule

bind jsp_top jsp_assert u_assert (
  .tck_i     (tck_i),
  .rst_i     (rst_i),
  .tap_i     (tap_i),
  .rx_push_i (rx_push),
  .tx_pop_i  (tx_pop),
  .rx_level_i(rx_level),
  .tx_level_i(tx_level),
  .tdo_i     (tdo_o)
);

// ==== dv/jsp_tb.sv ====
//////////////////////////////////////////////////
// JSP core testbench
// TAP data register model, FIFO queue model and
// scans in both directions
//////////////////////////////////////////////////

module jsp_tb
  import jsp_jtag_pkg::*;
  import jsp_buf_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic      tck_i = 1'b0;
  logic      rst_i;
  logic      tdi_i;
  tap_ctrl_t tap_i;
  dr_t       dr_i;
  logic      tdo_o;
  host_req_t host_i;
  host_rsp_t host_o;
  logic      sh_q;  // Shift pending from the last cycle

  byte_t       rx_model[$];  // Expected receive FIFO
  byte_t       tx_model[$];  // Expected transmit FIFO
  byte_t       got_q[$];
  byte_t       exp_q[$];
  string       what_q[$];
  fifo_level_t lvl_got_q[$];
  fifo_level_t lvl_exp_q[$];
  string       lvl_what_q[$];
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  always #10 tck_i = ~tck_i;  // 20 ns period

  jsp_top DUT (.*);

  //////////////////////////////////////////////////
  // Reference model and compare

  // Byte idx of a read scan, taken from the model at capture
  function automatic byte_t ref_scan_byte(int idx);
    if (idx == 0)
      return {count_t'(tx_model.size()), count_t'(FIFO_DEPTH - rx_model.size())};
    if (idx <= tx_model.size())
      return tx_model[idx-1];
    return '0;  // Snapshot used up
  endfunction

  function automatic fifo_level_t model_level();
    return '{used: count_t'(rx_model.size()), free: count_t'(FIFO_DEPTH - tx_model.size())};
  endfunction

  function automatic fifo_level_t host_level();
    return '{used: host_o.rx_used, free: host_o.tx_free};
  endfunction

  task automatic check_byte(byte_t got, byte_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(fifo_level_t got, fifo_level_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got used %0d free %0d, expected used %0d free %0d",
               $time, what, got.used, got.free, exp.used, exp.free);
    end
  endtask

  task automatic expect_byte(byte_t got, byte_t exp, string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endtask

  task automatic expect_level(fifo_level_t got, fifo_level_t exp, string what);
    lvl_got_q.push_back(got);
    lvl_exp_q.push_back(exp);
    lvl_what_q.push_back(what);
  endtask

  initial begin : compare
    forever begin
      @(posedge tck_i);
      while (got_q.size() > 0)
        check_byte(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
      while (lvl_got_q.size() > 0)
        check_level(lvl_got_q.pop_front(), lvl_exp_q.pop_front(), lvl_what_q.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // TAP and host drivers

  // One TCK cycle, driven on the falling edge
  task automatic tap_cycle(logic cap, logic sh, logic upd, logic bit_in, output logic tdo);
    @(negedge tck_i);
    if (sh_q)
      dr_i = {tdi_i, dr_i[DR_W-1:1]};  // DR took TDI at the last rising edge
    tdo   = tdo_o;                     // Bit shown in this shift cycle
    tap_i = '{capture: cap, shift: sh, update: upd, module_select: 1'b1};
    tdi_i = bit_in;
    sh_q  = sh;
  endtask

  // LSB first, optional pause mid-byte
  task automatic shift_byte(byte_t din, bit pause, output byte_t dout);
    logic t;
    for (int i = 0; i < BITS_PER_WORD; i++) begin
      if (pause && i == 3)
        tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);  // Pause-DR
      tap_cycle(1'b0, 1'b1, 1'b0, din[i], t);
      dout[i] = t;
    end
  endtask

  task automatic end_scan();
    logic t;
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);  // Update-DR
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic write_scan(int user_cnt, int nbytes, bit pause);
    int    snap;
    byte_t b;
    byte_t unused;
    logic  t;
    snap = FIFO_DEPTH - rx_model.size();  // Free space at capture
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);  // Leading zero from the chain
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);  // Start bit
    shift_byte(byte_t'(user_cnt << 4), pause, unused);
    for (int k = 0; k < nbytes; k++) begin
      b = byte_t'($urandom);
      shift_byte(b, pause, unused);
      if (k < user_cnt && k < snap)
        rx_model.push_back(b);
    end
    end_scan();
  endtask

  task automatic read_scan(int nbytes, bit pause);
    byte_t exp [16];
    byte_t got;
    logic  t;
    for (int k = 0; k < nbytes; k++)
      exp[k] = ref_scan_byte(k);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);  // Capture-DR
    for (int k = 0; k < nbytes; k++) begin
      shift_byte(8'h00, pause, got);
      if (k == 0)
        expect_level(fifo_level_t'(got), fifo_level_t'(exp[0]), "status byte");
      else
        expect_byte(got, exp[k], "TDO byte");
    end
    end_scan();
    // Last loaded byte gets no ack
    for (int k = 1; k < nbytes && tx_model.size() > 0; k++)
      void'(tx_model.pop_front());
  endtask

  task automatic host_write(byte_t b);
    @(negedge tck_i);
    host_i.wr    = 1'b1;
    host_i.wdata = b;
    if (tx_model.size() < FIFO_DEPTH)
      tx_model.push_back(b);
    @(negedge tck_i);
    host_i.wr = 1'b0;
  endtask

  task automatic host_read_all();
    while (rx_model.size() > 0) begin
      @(negedge tck_i);
      expect_level(host_level(), model_level(), "host levels");
      expect_byte(host_o.rdata, rx_model.pop_front(), "host read");
      host_i.rd = 1'b1;
      @(negedge tck_i);
      host_i.rd = 1'b0;
    end
    // Drained receive FIFO shows a zero head
    expect_level(host_level(), model_level(), "host levels after drain");
    expect_byte(host_o.rdata, 8'h00, "host read while empty");
  endtask

  task automatic wait_levels(string what);
    int n;
    n = 0;
    while (host_level() !== model_level() && n < 20) begin
      @(negedge tck_i);
      n++;
    end
    if (host_level() !== model_level()) begin
      timeouts++;
      $display("Timeout: host levels never settled after %s", what);
    end
    expect_level(host_level(), model_level(), what);
  endtask

  //////////////////////////////////////////////////
  // Scenarios

  initial begin : stimulus
    int n;
    void'($urandom(32'h12c88a9d));
    rst_i  = 1'b1;
    tdi_i  = 1'b0;
    tap_i  = '0;
    dr_i   = '0;
    host_i = '0;
    sh_q   = 1'b0;
    repeat (10) @(negedge tck_i);
    rst_i = 1'b0;

    read_scan(3, 1'b0);  // Status 0 used, 8 free
    wait_levels("reset");
    write_scan(4, 4, 1'b0);
    wait_levels("counted write");
    host_read_all();
    write_scan(2, 5, 1'b0);  // Bytes past the user count
    wait_levels("short count");
    host_read_all();
    write_scan(10, 10, 1'b0);  // More than the free space
    wait_levels("overfill");
    read_scan(2, 1'b0);  // Status shows 0 free
    host_read_all();
    for (int k = 0; k < 5; k++)
      host_write(byte_t'($urandom));
    wait_levels("host writes");
    read_scan(8, 1'b0);
    wait_levels("transmit drain");
    write_scan(3, 3, 1'b1);  // Same runs with pauses
    wait_levels("paused write");
    host_read_all();
    for (int k = 0; k < 4; k++)
      host_write(byte_t'($urandom));
    read_scan(7, 1'b1);
    wait_levels("paused read");

    n = 0;
    while ((got_q.size() + lvl_got_q.size()) > 0 && n < 10) begin
      @(negedge tck_i);
      n++;
    end
    if ((got_q.size() + lvl_got_q.size()) > 0) begin
      timeouts++;
      $display("Timeout: compare queues did not drain");
    end
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, DUT.u_assert.fails);
    if (errors == 0 && timeouts == 0 && DUT.u_assert.fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hw/jsp_buf_pkg.sv ====
//////////////////////////////////////////////////
// JSP buffer side definitions
// Byte and count types, FIFO depth and the
// host strobe port bundles
//////////////////////////////////////////////////

package jsp_buf_pkg;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [7:0] byte_t;
  typedef logic [3:0] count_t;  // 0 to FIFO_DEPTH

  // Occupancy seen from outside a FIFO
  typedef struct packed {
    count_t used;  // Bytes stored
    count_t free;  // Slots left
  } fifo_level_t;

  //////////////////////////////////////////////////
  // Host strobe port

  typedef struct packed {
    logic  wr;     // Push wdata into the transmit FIFO
    logic  rd;     // Pop the receive FIFO
    byte_t wdata;
  } host_req_t;

  typedef struct packed {
    byte_t  rdata;    // Receive FIFO head, 0 when empty
    count_t rx_used;
    count_t tx_free;
  } host_rsp_t;

endpackage

// ==== hw/jsp_byte_fifo.sv ====
//////////////////////////////////////////////////
// Byte FIFO with head word shown before the pop
// Reports used and free counts
//////////////////////////////////////////////////

module jsp_byte_fifo
  import jsp_buf_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        push_i,
  input  byte_t       push_data_i,
  input  logic        pop_i,
  output byte_t       head_o,
  output fifo_level_t level_o
);

  byte_t                 mem_q [FIFO_DEPTH];  // Storage array
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  count_t                used_q;              // Occupancy
  logic                  push_ok;
  logic                  pop_ok;

  // Full push and empty pop are dropped
  assign push_ok = push_i && (used_q != count_t'(FIFO_DEPTH));
  assign pop_ok  = pop_i && (used_q != '0);

  always_ff @(posedge tck_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      used_q   <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   used_q <= used_q + 1'b1;
        2'b01:   used_q <= used_q - 1'b1;
        default: used_q <= used_q;  // Both or neither
      endcase
    end
  end

  assign head_o = (used_q == '0) ? '0 : mem_q[rd_ptr_q];  // Zero while empty

  assign level_o.used = used_q;
  assign level_o.free = count_t'(FIFO_DEPTH) - used_q;

endmodule

// ==== hw/jsp_jtag_pkg.sv ====
//////////////////////////////////////////////////
// JSP TAP side definitions
// Data register layout, bit counting, FSM states
// and the TAP control bundle
//////////////////////////////////////////////////

package jsp_jtag_pkg;

  //////////////////////////////////////////////////
  // Data register layout

  localparam int DR_W          = 53;  // Width of the TAP data register
  localparam int DR_BYTE_LSB   = 46;  // Lowest bit of an assembled byte
  localparam int DR_COUNT_LSB  = 50;  // Lowest bit of the count nibble
  localparam int BITS_PER_WORD = 8;

  typedef logic [3:0]      bit_cnt_t;  // Bits shifted in the current word
  typedef logic [DR_W-1:0] dr_t;       // Shifts right, TDI enters at the top

  // TAP state decode for this module
  typedef struct packed {
    logic capture;        // Capture-DR
    logic shift;          // Shift-DR
    logic update;         // Update-DR
    logic module_select;  // JSP module selected by the debug unit
  } tap_ctrl_t;

  //////////////////////////////////////////////////
  // FSM states

  // Input side, JTAG into the receive FIFO
  typedef enum logic [1:0] {
    wr_idle,
    wr_wait,    // Hunting for the start bit
    wr_counts,  // Control byte with the user count
    wr_xfer
  } wr_state_t;

  // Output side, transmit FIFO out on TDO
  typedef enum logic [1:0] {
    rd_idle,
    rd_counts,  // Status byte goes out
    rd_rdack,   // Acknowledge the byte just loaded
    rd_xfer
  } rd_state_t;

endpackage

// ==== hw/jsp_read_ctrl.sv ====
//////////////////////////////////////////////////
// JSP output controller
// Shifts out the status byte, then buffered bytes
// from the transmit FIFO, LSB first on TDO
//////////////////////////////////////////////////

module jsp_read_ctrl
  import jsp_jtag_pkg::*;
  import jsp_buf_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  tap_ctrl_t   tap_i,
  input  byte_t       tx_head_i,
  input  fifo_level_t rx_level_i,
  input  fifo_level_t tx_level_i,
  output logic        pop_o,
  output logic        tdo_o
);

  rd_state_t state_q;
  rd_state_t state_d;
  bit_cnt_t  bit_cnt_q;   // Read bit counter
  count_t    out_cnt_q;   // Transmit bytes still to send
  byte_t     shift_q;     // Parallel load output shift register
  logic      start;       // Capture while selected
  logic      bit_max;     // Last bit of the current word
  logic      more;        // Another transmit byte pending
  logic      shifting;    // Shift-DR in an active state

  assign start    = (state_q == rd_idle) && tap_i.module_select && tap_i.capture;
  assign bit_max  = (bit_cnt_q == bit_cnt_t'(BITS_PER_WORD - 1));
  assign more     = (out_cnt_q != '0);
  assign shifting = tap_i.shift && (state_q != rd_idle);

  // Ack one shift cycle after the load
  assign pop_o = shifting && (state_q == rd_rdack) && more;
  assign tdo_o = shift_q[0];

  //////////////////////////////////////////////////
  // Output FSM

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= rd_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      rd_idle: begin
        if (start) begin
          state_d = rd_counts;
        end
      end
      rd_rdack: begin
        if (tap_i.shift) begin
          state_d = rd_xfer;  // Pause keeps the ack pending
        end
      end
      default: begin
        // Counts and xfer both end at a word boundary
        if (tap_i.shift && bit_max) begin
          state_d = rd_rdack;
        end
      end
    endcase
    if (tap_i.update) begin
      state_d = rd_idle;
    end
  end

  //////////////////////////////////////////////////
  // Counters and shift register

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
    end else if (start) begin
      bit_cnt_q <= '0;
      out_cnt_q <= tx_level_i.used;  // Snapshot of bytes to send
    end else if (shifting) begin
      if (bit_max) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (pop_o) begin
        out_cnt_q <= out_cnt_q - 1'b1;  // Counted off at the ack
      end
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q <= '0;
    end else if (start) begin
      shift_q <= {tx_level_i.used, rx_level_i.free};  // Status byte
    end else if (shifting) begin
      if (bit_max) begin
        shift_q <= more ? tx_head_i : '0;  // Zeros once the snapshot runs out
      end else begin
        shift_q <= {1'b0, shift_q[7:1]};
      end
    end
  end

endmodule

// ==== hw/jsp_top.sv ====
//////////////////////////////////////////////////
// JSP core, TCK side
// Input and output controllers around the
// receive and transmit byte FIFOs
//////////////////////////////////////////////////

module jsp_top
  import jsp_jtag_pkg::*;
  import jsp_buf_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      tdi_i,
  input  tap_ctrl_t tap_i,
  input  dr_t       dr_i,
  output logic      tdo_o,
  input  host_req_t host_i,
  output host_rsp_t host_o
);

  logic        rx_push;   // Byte from JTAG into receive FIFO
  logic        tx_pop;    // Ack of a byte sent on TDO
  byte_t       rx_data;
  byte_t       rx_head;
  byte_t       tx_head;
  fifo_level_t rx_level;
  fifo_level_t tx_level;

  jsp_write_ctrl u_write_ctrl (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .tdi_i      (tdi_i),
    .tap_i      (tap_i),
    .dr_i       (dr_i),
    .rx_free_i  (rx_level.free),
    .push_o     (rx_push),
    .push_data_o(rx_data)
  );

  jsp_read_ctrl u_read_ctrl (
    .tck_i     (tck_i),
    .rst_i     (rst_i),
    .tap_i     (tap_i),
    .tx_head_i (tx_head),
    .rx_level_i(rx_level),
    .tx_level_i(tx_level),
    .pop_o     (tx_pop),
    .tdo_o     (tdo_o)
  );

  // JTAG to host
  jsp_byte_fifo rx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (rx_push),
    .push_data_i(rx_data),
    .pop_i      (host_i.rd),
    .head_o     (rx_head),
    .level_o    (rx_level)
  );

  // Host to JTAG
  jsp_byte_fifo tx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .push_i     (host_i.wr),
    .push_data_i(host_i.wdata),
    .pop_i      (tx_pop),
    .head_o     (tx_head),
    .level_o    (tx_level)
  );

  assign host_o = '{rdata: rx_head, rx_used: rx_level.used, tx_free: tx_level.free};

endmodule

// ==== hw/jsp_write_ctrl.sv ====
//////////////////////////////////////////////////
// JSP input controller
// Waits for the start bit, takes the user count
// from the control byte, then pushes shifted-in
// bytes into the receive FIFO
//////////////////////////////////////////////////

module jsp_write_ctrl
  import jsp_jtag_pkg::*;
  import jsp_buf_pkg::*;
(
  input  logic      tck_i,
  input  logic      rst_i,
  input  logic      tdi_i,
  input  tap_ctrl_t tap_i,
  input  dr_t       dr_i,
  input  count_t    rx_free_i,
  output logic      push_o,
  output byte_t     push_data_o
);

  wr_state_t state_q;
  wr_state_t state_d;
  bit_cnt_t  bit_cnt_q;   // Write bit counter
  count_t    in_cnt_q;    // Receive space left, snapshot at capture
  count_t    user_cnt_q;  // Bytes the user still announces
  logic      start;       // Capture while selected
  logic      bit_max;     // 8th bit of a word on TDI now
  logic      byte_ok;     // Both counters allow a push
  logic      counting;    // Bit counter runs this cycle

  //////////////////////////////////////////////////
  // Byte assembly

  // Seven bits already in the register, the 8th is still on TDI
  assign push_data_o = {tdi_i, dr_i[DR_W-1:DR_BYTE_LSB]};

  assign start    = (state_q == wr_idle) && tap_i.module_select && tap_i.capture;
  assign bit_max  = (bit_cnt_q == bit_cnt_t'(BITS_PER_WORD - 1));
  assign byte_ok  = (in_cnt_q != '0) && (user_cnt_q != '0);
  assign counting = tap_i.shift && ((state_q == wr_counts) || (state_q == wr_xfer));

  assign push_o = counting && (state_q == wr_xfer) && bit_max && byte_ok;

  //////////////////////////////////////////////////
  // Input FSM

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= wr_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      wr_idle: begin
        if (start) begin
          state_d = wr_wait;
        end
      end
      wr_wait: begin
        // Devices ahead in the chain give leading zeros
        if (tap_i.shift && tap_i.module_select && tdi_i) begin
          state_d = wr_counts;
        end
      end
      wr_counts: begin
        if (tap_i.shift && bit_max) begin
          state_d = wr_xfer;  // Control byte complete
        end
      end
      default: begin
        state_d = state_q;  // Stay in xfer until update
      end
    endcase
    if (tap_i.update) begin
      state_d = wr_idle;
    end
  end

  //////////////////////////////////////////////////
  // Counters

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q  <= '0;
      in_cnt_q   <= '0;
      user_cnt_q <= '0;
    end else if (start) begin
      bit_cnt_q <= '0;
      in_cnt_q  <= rx_free_i;  // Free space snapshot
    end else if (counting) begin  // Frozen in pause and exit
      if (bit_max) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if ((state_q == wr_counts) && bit_max) begin
        user_cnt_q <= {tdi_i, dr_i[DR_W-1:DR_COUNT_LSB]};  // Upper nibble of control
      end
      if (push_o) begin
        in_cnt_q   <= in_cnt_q - 1'b1;
        user_cnt_q <= user_cnt_q - 1'b1;
      end
    end
  end

endmodule

// ==== list.f ====
hw/jsp_jtag_pkg.sv
hw/jsp_buf_pkg.sv
hw/jsp_byte_fifo.sv
hw/jsp_write_ctrl.sv
hw/jsp_read_ctrl.sv
hw/jsp_top.sv
dv/jsp_assert.sv
dv/jsp_tb.sv
